/* files.f */
+incdir+.
corePkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memStage.sv
writebackStage.sv
hazardUnit.sv
pipeCore.sv
coreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module coreTb

out=$(./obj_dir/VcoreTb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi

/* coreTb.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module coreTb;
  import corePkg::*;

  localparam int NumInstr  = 200;              // Self-loop sits right after these
  localparam int MaxCycles = 4 * NumInstr + 50;
  localparam int TailHits  = 8;                // Self-loop fetches seen before ending

  typedef enum int {
    INS_ADD, INS_SUB, INS_AND, INS_OR, INS_SLT, INS_ADDI, INS_LW, INS_SW, INS_BEQ
  } insKind_e;

  logic    clk;
  logic    rst;
  word_t   instrF;
  word_t   readDataM;
  word_t   pcF;
  word_t   dataAddrM;
  word_t   writeDataM;
  logic    memWriteM;
  logic    regWriteW;
  regIdx_t rdW;
  word_t   resultW;

  word_t    imem [0:255];
  word_t    dmem [0:63];
  insKind_e kindA [0:255];
  regIdx_t  rdA [0:255];
  regIdx_t  rs1A [0:255];
  regIdx_t  rs2A [0:255];
  word_t    immA [0:255];

  regIdx_t expRd[$];     // Writebacks in program order
  word_t   expVal[$];
  word_t   expAddr[$];   // Stores in program order
  word_t   expData[$];

  integer seed;
  int     wbIdx;
  int     stIdx;
  int     cycles;

  pipeCore DUT (
    .clk(clk), .rst(rst), .instrF(instrF), .readDataM(readDataM), .pcF(pcF),
    .dataAddrM(dataAddrM), .writeDataM(writeDataM), .memWriteM(memWriteM),
    .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Both memories answer in the same cycle
  always_comb begin
    instrF    = imem[pcF[9:2]];
    readDataM = dmem[dataAddrM[7:2]];
  end

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic word_t fillWord(int a);
    return (word_t'(a) * 32'h9E37_79B9) ^ 32'hA5A5_0F0F;  // Differs for every word
  endfunction

  function automatic word_t encodeInstr(insKind_e k, regIdx_t rd, regIdx_t rs1,
                                        regIdx_t rs2, word_t imm);
    case (k)
      INS_ADD:  return {7'b0, rs2, rs1, `F3_ADD, rd, `OP_RTYPE};
      INS_SUB:  return {`F7_SUB, rs2, rs1, `F3_ADD, rd, `OP_RTYPE};
      INS_AND:  return {7'b0, rs2, rs1, `F3_AND, rd, `OP_RTYPE};
      INS_OR:   return {7'b0, rs2, rs1, `F3_OR, rd, `OP_RTYPE};
      INS_SLT:  return {7'b0, rs2, rs1, `F3_SLT, rd, `OP_RTYPE};
      INS_ADDI: return {imm[11:0], rs1, `F3_ADD, rd, `OP_ITYPE};
      INS_LW:   return {imm[11:0], rs1, 3'b010, rd, `OP_LOAD};
      INS_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
      default:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `OP_BRANCH};
    endcase
  endfunction

  task automatic buildProgram();
    int off;
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = `NOP_INSTR;
    end
    for (int i = 0; i < NumInstr; i++) begin
      kindA[i[7:0]] = insKind_e'(randBelow(9));
      rdA[i[7:0]]   = regIdx_t'(randBelow(8));  // Few registers so hazards are common
      rs1A[i[7:0]]  = regIdx_t'(randBelow(8));
      rs2A[i[7:0]]  = regIdx_t'(randBelow(8));
      immA[i[7:0]]  = '0;
      case (kindA[i[7:0]])
        INS_ADDI: immA[i[7:0]] = word_t'(randBelow(4096) - 2048);
        INS_LW, INS_SW: begin
          rs1A[i[7:0]] = '0;
          immA[i[7:0]] = word_t'(randBelow(64) * 4);
        end
        INS_BEQ: begin
          off = 2 + randBelow(5);
          if (i + off > NumInstr) begin
            off = NumInstr - i;  // Never jump past the self-loop
          end
          immA[i[7:0]] = word_t'(off * 4);
        end
        default: ;
      endcase
      imem[i[7:0]] = encodeInstr(kindA[i[7:0]], rdA[i[7:0]], rs1A[i[7:0]],
                                 rs2A[i[7:0]], immA[i[7:0]]);
    end
    imem[NumInstr] = encodeInstr(INS_BEQ, '0, '0, '0, '0);  // beq x0, x0, 0
    for (int a = 0; a < 64; a++) begin
      dmem[a[5:0]] = fillWord(a);
    end
  endtask

  // In-order reference run of the same program
  task automatic runModel();
    word_t   mRegs [0:31];
    word_t   mMem [0:63];
    word_t   a;
    word_t   b;
    word_t   imm;
    word_t   res;
    regIdx_t rd;
    int      pc;
    for (int r = 0; r < 32; r++) begin
      mRegs[r[4:0]] = '0;
    end
    for (int w = 0; w < 64; w++) begin
      mMem[w[5:0]] = fillWord(w);
    end
    pc = 0;
    while (pc != NumInstr) begin
      a   = mRegs[rs1A[pc[7:0]]];
      b   = mRegs[rs2A[pc[7:0]]];
      imm = immA[pc[7:0]];
      rd  = rdA[pc[7:0]];
      res = '0;
      case (kindA[pc[7:0]])
        INS_ADD:  res = a + b;
        INS_SUB:  res = a - b;
        INS_AND:  res = a & b;
        INS_OR:   res = a | b;
        INS_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        INS_ADDI: res = a + imm;
        INS_LW:   res = mMem[imm[7:2]];
        default:  ;
      endcase
      if (kindA[pc[7:0]] == INS_SW) begin
        mMem[imm[7:2]] = b;
        expAddr.push_back(imm);
        expData.push_back(b);
        pc++;
      end else if (kindA[pc[7:0]] == INS_BEQ) begin
        pc = (a == b) ? pc + int'(imm >> 2) : pc + 1;
      end else begin
        if (rd != '0) begin  // x0 writes are invisible at the ports
          mRegs[rd] = res;
          expRd.push_back(rd);
          expVal.push_back(res);
        end
        pc++;
      end
    end
  endtask

  task automatic reportMismatch(string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic reportTimeout();
    $display("Timeout after %0d cycles: %0d of %0d writebacks and %0d of %0d stores seen",
             cycles, wbIdx, expRd.size(), stIdx, expAddr.size());
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // Sampled on the falling edge, away from the register updates
  task automatic checkPorts();
    if (regWriteW && rdW != '0) begin
      assert (wbIdx < expRd.size())
        else reportMismatch($sformatf("unexpected writeback x%0d = %h", rdW, resultW));
      assert (rdW == expRd[wbIdx] && resultW == expVal[wbIdx])
        else reportMismatch($sformatf("writeback %0d: got x%0d = %h, expected x%0d = %h",
                                      wbIdx, rdW, resultW, expRd[wbIdx], expVal[wbIdx]));
      wbIdx++;
    end
    if (memWriteM) begin
      assert (stIdx < expAddr.size())
        else reportMismatch($sformatf("unexpected store [%h] = %h", dataAddrM, writeDataM));
      assert (dataAddrM == expAddr[stIdx] && writeDataM == expData[stIdx])
        else reportMismatch($sformatf("store %0d: got [%h] = %h, expected [%h] = %h",
                                      stIdx, dataAddrM, writeDataM,
                                      expAddr[stIdx], expData[stIdx]));
      dmem[dataAddrM[7:2]] = writeDataM;
      stIdx++;
    end
  endtask

  initial begin
    int tail;
    rst    = 1'b1;
    seed   = 39421;
    wbIdx  = 0;
    stIdx  = 0;
    cycles = 0;
    tail   = 0;
    buildProgram();
    runModel();
    repeat (2) @(negedge clk);
    assert (!regWriteW && !memWriteM && pcF == `RESET_PC)
      else reportMismatch("core not idle at PC zero during reset");
    rst = 1'b0;
    while (tail < TailHits) begin
      @(negedge clk);
      cycles++;
      checkPorts();
      if (cycles >= MaxCycles) begin
        reportTimeout();
      end
      if (wbIdx == expRd.size() && stIdx == expAddr.size() && pcF == word_t'(NumInstr * 4)) begin
        tail++;  // Parked on the self-loop
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

/* pipeCore.sv */
`timescale 1ns/1ps

module pipeCore (
  input  logic           clk,
  input  logic           rst,
  input  corePkg::word_t instrF,
  input  corePkg::word_t readDataM,
  output corePkg::word_t pcF,
  output corePkg::word_t dataAddrM,
  output corePkg::word_t writeDataM,
  output logic           memWriteM,
  output logic           regWriteW,
  output corePkg::regIdx_t rdW,
  output corePkg::word_t resultW
);
  import corePkg::*;

  logic       stallF;
  logic       stallD;
  logic       flushD;
  logic       flushE;
  logic       pcSrcE;
  word_t      branchTargetE;
  regIdx_t    rs1D;
  regIdx_t    rs2D;
  word_t      rd1D;
  word_t      rd2D;
  decToEx_t   decOut;
  fwdSel_e    forwardAE;
  fwdSel_e    forwardBE;
  regIdx_t    rs1E;
  regIdx_t    rs2E;
  regIdx_t    rdE;
  resultSrc_e resultSrcE;
  exToMem_t   exOut;
  regIdx_t    rdM;
  logic       regWriteM;
  word_t      aluResultM;
  memToWb_t   memOut;

  fetchStage uFetch (
    .clk(clk), .rst(rst), .stallF(stallF), .pcSrcE(pcSrcE),
    .branchTargetE(branchTargetE), .pcF(pcF)
  );

  regFile uRegFile (
    .clk(clk), .rst(rst), .rs1D(rs1D), .rs2D(rs2D), .rdW(rdW),
    .regWriteW(regWriteW), .resultW(resultW), .rd1D(rd1D), .rd2D(rd2D)
  );

  decodeStage uDecode (
    .clk(clk), .rst(rst), .stallD(stallD), .flushD(flushD), .pcF(pcF),
    .instrF(instrF), .rd1D(rd1D), .rd2D(rd2D), .rs1D(rs1D), .rs2D(rs2D),
    .decOut(decOut)
  );

  executeStage uExecute (
    .clk(clk), .rst(rst), .flushE(flushE), .decOut(decOut),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .aluResultM(aluResultM),
    .resultW(resultW), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
    .resultSrcE(resultSrcE), .pcSrcE(pcSrcE), .branchTargetE(branchTargetE),
    .exOut(exOut)
  );

  memStage uMem (
    .clk(clk), .rst(rst), .exOut(exOut), .dataAddrM(dataAddrM),
    .writeDataM(writeDataM), .memWriteM(memWriteM), .rdM(rdM),
    .regWriteM(regWriteM), .aluResultM(aluResultM), .readDataM(readDataM),
    .memOut(memOut)
  );

  writebackStage uWriteback (
    .clk(clk), .rst(rst), .memOut(memOut), .regWriteW(regWriteW),
    .rdW(rdW), .resultW(resultW)
  );

  hazardUnit uHazard (
    .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
    .rdM(rdM), .rdW(rdW), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .resultSrcE(resultSrcE), .pcSrcE(pcSrcE), .stallF(stallF),
    .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .forwardAE(forwardAE), .forwardBE(forwardBE)
  );

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
  input  corePkg::regIdx_t    rs1D,
  input  corePkg::regIdx_t    rs2D,
  input  corePkg::regIdx_t    rs1E,
  input  corePkg::regIdx_t    rs2E,
  input  corePkg::regIdx_t    rdE,
  input  corePkg::regIdx_t    rdM,
  input  corePkg::regIdx_t    rdW,
  input  logic                regWriteM,
  input  logic                regWriteW,
  input  corePkg::resultSrc_e resultSrcE,
  input  logic                pcSrcE,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD,
  output logic                flushE,
  output corePkg::fwdSel_e    forwardAE,
  output corePkg::fwdSel_e    forwardBE
);
  import corePkg::*;

  logic ldStall;

  // Memory stage wins over writeback, x0 never forwards
  function automatic fwdSel_e fwdSelect(regIdx_t rs, regIdx_t rdMem, logic wrMem,
                                        regIdx_t rdWb, logic wrWb);
    if (rs != '0 && rs == rdMem && wrMem) begin
      return FWD_MEM;
    end else if (rs != '0 && rs == rdWb && wrWb) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    forwardAE = fwdSelect(rs1E, rdM, regWriteM, rdW, regWriteW);
    forwardBE = fwdSelect(rs2E, rdM, regWriteM, rdW, regWriteW);
  end

  // Load in execute feeding the instruction in decode
  assign ldStall = (resultSrcE == RES_MEM) && (rdE == rs1D || rdE == rs2D);

  assign stallF = ldStall;
  assign stallD = ldStall;
  assign flushE = ldStall || pcSrcE;  // Bubble into execute
  assign flushD = pcSrcE;             // Drop wrong-path fetch

endmodule

/* writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
  input  logic               clk,
  input  logic               rst,
  input  corePkg::memToWb_t  memOut,
  output logic               regWriteW,
  output corePkg::regIdx_t   rdW,
  output corePkg::word_t     resultW
);
  import corePkg::*;

  memToWb_t mwReg;

  // Memory/writeback register
  always_ff @(posedge clk) begin
    mwReg <= memOut;
    if (rst) begin
      mwReg.regWrite  <= 1'b0;
      mwReg.resultSrc <= RES_ALU;
    end
  end

  assign regWriteW = mwReg.regWrite;
  assign rdW       = mwReg.rd;
  assign resultW   = (mwReg.resultSrc == RES_MEM) ? mwReg.readData : mwReg.aluResult;

endmodule

/* memStage.sv */
`timescale 1ns/1ps

module memStage (
  input  logic               clk,
  input  logic               rst,
  input  corePkg::exToMem_t  exOut,
  output corePkg::word_t     dataAddrM,
  output corePkg::word_t     writeDataM,
  output logic               memWriteM,
  output corePkg::regIdx_t   rdM,
  output logic               regWriteM,
  output corePkg::word_t     aluResultM,
  input  corePkg::word_t     readDataM,
  output corePkg::memToWb_t  memOut
);
  import corePkg::*;

  exToMem_t emReg;

  // Execute/memory register
  always_ff @(posedge clk) begin
    emReg <= exOut;
    if (rst) begin
      emReg.regWrite  <= 1'b0;
      emReg.memWrite  <= 1'b0;
      emReg.resultSrc <= RES_ALU;
    end
  end

  // Data memory port
  assign dataAddrM  = emReg.aluResult;
  assign writeDataM = emReg.writeData;
  assign memWriteM  = emReg.memWrite;

  assign rdM        = emReg.rd;
  assign regWriteM  = emReg.regWrite;
  assign aluResultM = emReg.aluResult;  // Forwarded to execute

  always_comb begin
    memOut.regWrite  = emReg.regWrite;
    memOut.resultSrc = emReg.resultSrc;
    memOut.aluResult = emReg.aluResult;
    memOut.readData  = readDataM;  // Load data answers same cycle
    memOut.rd        = emReg.rd;
  end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic                clk,
  input  logic                rst,
  input  logic                flushE,
  input  corePkg::decToEx_t   decOut,
  input  corePkg::fwdSel_e    forwardAE,
  input  corePkg::fwdSel_e    forwardBE,
  input  corePkg::word_t      aluResultM,
  input  corePkg::word_t      resultW,
  output corePkg::regIdx_t    rs1E,
  output corePkg::regIdx_t    rs2E,
  output corePkg::regIdx_t    rdE,
  output corePkg::resultSrc_e resultSrcE,
  output logic                pcSrcE,
  output corePkg::word_t      branchTargetE,
  output corePkg::exToMem_t   exOut
);
  import corePkg::*;

  decToEx_t deReg;
  word_t    srcAE;
  word_t    srcBE;
  word_t    writeDataE;
  word_t    aluResultE;

  function automatic word_t fwdMux(fwdSel_e sel, word_t regVal, word_t memVal, word_t wbVal);
    case (sel)
      FWD_MEM: return memVal;
      FWD_WB:  return wbVal;
      default: return regVal;
    endcase
  endfunction

  // Decode/execute register
  always_ff @(posedge clk) begin
    deReg <= decOut;
    if (rst || flushE) begin
      deReg.ctrl <= '0;  // Bubble
    end
  end

  assign srcAE      = fwdMux(forwardAE, deReg.rs1Data, aluResultM, resultW);
  assign writeDataE = fwdMux(forwardBE, deReg.rs2Data, aluResultM, resultW);
  assign srcBE      = deReg.ctrl.aluSrcImm ? deReg.imm : writeDataE;

  always_comb begin
    case (deReg.ctrl.aluOp)
      ALU_ADD: aluResultE = srcAE + srcBE;
      ALU_SUB: aluResultE = srcAE - srcBE;
      ALU_AND: aluResultE = srcAE & srcBE;
      ALU_OR:  aluResultE = srcAE | srcBE;
      ALU_SLT: aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
      default: aluResultE = srcAE + srcBE;
    endcase
  end

  // BEQ resolves here
  assign pcSrcE        = deReg.ctrl.branch && (aluResultE == '0);
  assign branchTargetE = deReg.pc + deReg.imm;

  // Seen by the hazard unit
  assign rs1E       = deReg.rs1;
  assign rs2E       = deReg.rs2;
  assign rdE        = deReg.rd;
  assign resultSrcE = deReg.ctrl.resultSrc;

  always_comb begin
    exOut.regWrite  = deReg.ctrl.regWrite;
    exOut.memWrite  = deReg.ctrl.memWrite;
    exOut.resultSrc = deReg.ctrl.resultSrc;
    exOut.aluResult = aluResultE;
    exOut.writeData = writeDataE;
    exOut.rd        = deReg.rd;
  end

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module decodeStage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stallD,
  input  logic               flushD,
  input  corePkg::word_t     pcF,
  input  corePkg::word_t     instrF,
  input  corePkg::word_t     rd1D,
  input  corePkg::word_t     rd2D,
  output corePkg::regIdx_t   rs1D,
  output corePkg::regIdx_t   rs2D,
  output corePkg::decToEx_t  decOut
);
  import corePkg::*;

  word_t      instrD;
  word_t      pcD;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      iImm;
  word_t      sImm;
  word_t      bImm;
  word_t      immD;
  aluOp_e     aluOpD;
  logic       aluKnown;
  ctrl_t      ctrlD;

  // Fetch/decode register
  always_ff @(posedge clk) begin
    if (rst || flushD) begin
      instrD <= `NOP_INSTR;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      pcD <= pcF;
    end
  end

  assign opcode = instrD[6:0];
  assign funct3 = instrD[14:12];
  assign funct7 = instrD[31:25];
  assign rs1D   = instrD[19:15];
  assign rs2D   = instrD[24:20];

  assign iImm = {{20{instrD[31]}}, instrD[31:20]};
  assign sImm = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
  assign bImm = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};

  always_comb begin
    aluOpD   = ALU_ADD;
    aluKnown = 1'b1;
    case (funct3)
      // funct7 only means something for register-register ops
      `F3_ADD: aluOpD = (opcode == `OP_RTYPE && funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
      `F3_SLT: aluOpD = ALU_SLT;
      `F3_OR:  aluOpD = ALU_OR;
      `F3_AND: aluOpD = ALU_AND;
      default: aluKnown = 1'b0;
    endcase
  end

  always_comb begin
    ctrlD = '0;  // Bubble unless recognised
    immD  = iImm;
    case (opcode)
      `OP_RTYPE: begin
        ctrlD.regWrite = aluKnown;
        ctrlD.aluOp    = aluOpD;
      end
      `OP_ITYPE: begin
        ctrlD.regWrite  = aluKnown;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = aluOpD;
      end
      `OP_LOAD: begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.resultSrc = RES_MEM;
      end
      `OP_STORE: begin
        ctrlD.memWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        immD            = sImm;
      end
      `OP_BRANCH: begin
        ctrlD.branch = 1'b1;
        ctrlD.aluOp  = ALU_SUB;  // Equality via zero difference
        immD         = bImm;
      end
      default: begin
        ctrlD = '0;
      end
    endcase
  end

  always_comb begin
    decOut.ctrl    = ctrlD;
    decOut.pc      = pcD;
    decOut.rs1Data = rd1D;
    decOut.rs2Data = rd2D;
    decOut.imm     = immD;
    decOut.rs1     = rs1D;
    decOut.rs2     = rs2D;
    decOut.rd      = instrD[11:7];
  end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic              clk,
  input  logic              rst,
  input  corePkg::regIdx_t  rs1D,
  input  corePkg::regIdx_t  rs2D,
  input  corePkg::regIdx_t  rdW,
  input  logic              regWriteW,
  input  corePkg::word_t    resultW,
  output corePkg::word_t    rd1D,
  output corePkg::word_t    rd2D
);
  import corePkg::*;

  word_t regs [1:31];  // x0 has no storage

  // Write in W is seen by a read in D in the same cycle
  function automatic word_t readReg(regIdx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (regWriteW && idx == rdW) begin
      return resultW;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;  // Architectural state starts at zero
      end
    end else if (regWriteW && rdW != '0) begin
      regs[rdW] <= resultW;
    end
  end

  always_comb begin
    rd1D = readReg(rs1D);
    rd2D = readReg(rs2D);
  end

endmodule

/* fetchStage.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module fetchStage (
  input  logic           clk,
  input  logic           rst,
  input  logic           stallF,
  input  logic           pcSrcE,
  input  corePkg::word_t branchTargetE,
  output corePkg::word_t pcF
);
  import corePkg::*;

  word_t pcNext;

  always_comb begin
    if (pcSrcE) begin
      pcNext = branchTargetE;  // Taken branch resolved in execute
    end else if (stallF) begin
      pcNext = pcF;            // Load-use hold
    end else begin
      pcNext = pcF + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= `RESET_PC;
    end else begin
      pcF <= pcNext;
    end
  end

endmodule

/* corePkg.sv */
package corePkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOp_e;

  typedef enum logic {
    RES_ALU,
    RES_MEM
  } resultSrc_e;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwdSel_e;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       aluSrcImm;  // Second operand from immediate
    resultSrc_e resultSrc;
    aluOp_e     aluOp;
  } ctrl_t;

  typedef struct packed {
    ctrl_t   ctrl;
    word_t   pc;
    word_t   rs1Data;
    word_t   rs2Data;
    word_t   imm;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
  } decToEx_t;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    resultSrc_e resultSrc;
    word_t      aluResult;
    word_t      writeData;  // Store data after forwarding
    regIdx_t    rd;
  } exToMem_t;

  typedef struct packed {
    logic       regWrite;
    resultSrc_e resultSrc;
    word_t      aluResult;
    word_t      readData;
    regIdx_t    rd;
  } memToWb_t;

endpackage

/* pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Major opcodes
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

// Function codes
`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F7_SUB 7'b0100000

`define RESET_PC  32'h0000_0000
`define NOP_INSTR 32'h0000_0013 // addi x0, x0, 0

`endif
